// ==== verilog/soc_ctrl_pkg.sv ====
// shared types for the system-control subsystem
// AXI-lite style bus structs, address map, response codes
// boot timing constants and the boot sequencer state type
package soc_ctrl_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [1:0]  resp_t;
  typedef logic [3:0]  win_t;      // address bits 19 to 16
  typedef logic [15:0] reg_off_t;  // register offset inside a window

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_DECERR = 2'd3;

  typedef struct packed {
    logic  awvalid;
    addr_t awaddr;
    logic  wvalid;
    data_t wdata;
    logic  bready;
    logic  arvalid;
    addr_t araddr;
    logic  rready;
  } s_axi_mosi_t;

  typedef struct packed {
    logic  awready;
    logic  wready;
    logic  bvalid;
    resp_t bresp;
    logic  arready;
    logic  rvalid;
    data_t rdata;
    resp_t rresp;
    logic  rlast;
  } s_axi_miso_t;

  // address map
  localparam win_t     RST_CTRL_WINDOW = 4'd0;
  localparam win_t     SCRATCH_WINDOW  = 4'd1;
  localparam reg_off_t REG_RST_VECTOR  = 16'h0000;
  localparam reg_off_t REG_SOFT_RST    = 16'h0004;
  localparam int       SCRATCH_WORDS   = 4;
  localparam int       SCRATCH_IDX_W   = $clog2(SCRATCH_WORDS);

  localparam data_t RST_VECTOR_DEFAULT = 32'h8000_0000;  // boot address after power-on
  localparam int    CORE_RST_HOLD      = 8;               // core reset length in cycles
  localparam int    HOLD_CNT_W         = $clog2(CORE_RST_HOLD);
  localparam data_t DECERR_DATA        = 32'hdead_beef;

  typedef enum logic {
    HOLD,
    RUN
  } boot_state_t;

endpackage

// ==== verilog/rst_ctrl.sv ====
// reset controller target on the AXI-lite bus
// holds the boot vector register and the soft-reset command register
`timescale 1ns/1ps

module rst_ctrl (
  input  logic                      clk,
  input  logic                      rd_rst_ff,
  input  soc_ctrl_pkg::s_axi_mosi_t axi_mosi,
  output soc_ctrl_pkg::s_axi_miso_t axi_miso,
  output soc_ctrl_pkg::data_t       rst_vector,
  output logic                      soft_rst_req
);
  import soc_ctrl_pkg::*;

  data_t    rst_vec_ff;
  logic     wr_pend_ff;
  reg_off_t wr_off_ff;
  logic     rd_pend_ff;
  reg_off_t rd_off_ff;
  logic     bvalid_ff;
  logic     soft_rst_ff;
  logic     aw_fire;
  logic     w_fire;
  logic     ar_fire;

  assign aw_fire = axi_mosi.awvalid;                // awready is always high
  assign w_fire  = axi_mosi.wvalid && wr_pend_ff;
  assign ar_fire = axi_mosi.arvalid;

  assign rst_vector   = rst_vec_ff;
  assign soft_rst_req = soft_rst_ff;  // lines up with the first bvalid cycle

  always_comb begin
    axi_miso         = '0;
    axi_miso.awready = 1'b1;
    axi_miso.wready  = wr_pend_ff;
    axi_miso.bvalid  = bvalid_ff;
    axi_miso.bresp   = RESP_OKAY;
    axi_miso.arready = 1'b1;
    axi_miso.rvalid  = rd_pend_ff;
    axi_miso.rlast   = rd_pend_ff;
    axi_miso.rresp   = RESP_OKAY;
    // soft-reset register and unknown offsets read back as zero
    if (rd_pend_ff && (rd_off_ff == REG_RST_VECTOR)) begin
      axi_miso.rdata = rst_vec_ff;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_rst_ff) begin
      rst_vec_ff  <= RST_VECTOR_DEFAULT;
      wr_pend_ff  <= 1'b0;
      rd_pend_ff  <= 1'b0;
      bvalid_ff   <= 1'b0;
      soft_rst_ff <= 1'b0;
    end else begin
      if (w_fire) begin
        wr_pend_ff <= 1'b0;
      end
      if (aw_fire) begin
        wr_pend_ff <= 1'b1;
      end

      if (w_fire) begin
        bvalid_ff <= 1'b1;
      end else if (axi_mosi.bready) begin
        bvalid_ff <= 1'b0;
      end

      if (rd_pend_ff && axi_mosi.rready) begin
        rd_pend_ff <= 1'b0;
      end
      if (ar_fire) begin
        rd_pend_ff <= 1'b1;
      end

      if (w_fire && (wr_off_ff == REG_RST_VECTOR)) begin
        rst_vec_ff <= axi_mosi.wdata;
      end
      soft_rst_ff <= w_fire && (wr_off_ff == REG_SOFT_RST) && axi_mosi.wdata[0];
    end
  end

  // the offsets only matter while the matching pending flag is set
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_off_ff <= axi_mosi.awaddr[15:0];
    end
    if (ar_fire) begin
      rd_off_ff <= axi_mosi.araddr[15:0];
    end
  end

  // a soft-reset command must reach the sequencer as a single pulse
  soft_rst_pulse: assert property (@(posedge clk) disable iff (rd_rst_ff)
    soft_rst_req |=> !soft_rst_req);

endmodule

// ==== verilog/axi_periph_decode.sv ====
// peripheral address decoder for the AXI-lite master port
// steers one write and one read at a time by address window
// and answers unmapped windows with a decode error
`timescale 1ns/1ps

module axi_periph_decode (
  input  logic                      clk,
  input  logic                      rd_rst_ff,
  input  soc_ctrl_pkg::s_axi_mosi_t axi_mosi,
  output soc_ctrl_pkg::s_axi_miso_t axi_miso,
  output soc_ctrl_pkg::s_axi_mosi_t rst_mosi,
  input  soc_ctrl_pkg::s_axi_miso_t rst_miso,
  output soc_ctrl_pkg::s_axi_mosi_t scratch_mosi,
  input  soc_ctrl_pkg::s_axi_miso_t scratch_miso
);
  import soc_ctrl_pkg::*;

  logic        wr_open_ff;
  win_t        wr_win_ff;
  logic        rd_open_ff;
  win_t        rd_win_ff;
  logic        bvalid_ff;
  resp_t       bresp_ff;
  logic        rvalid_ff;
  data_t       rdata_ff;
  resp_t       rresp_ff;
  logic        rlast_ff;
  win_t        aw_win;
  win_t        ar_win;
  logic        aw_fire;
  logic        w_fire;
  logic        ar_fire;
  logic        ar_unmapped;
  logic        wr_sel_rst;
  logic        wr_sel_scr;
  logic        wr_unmapped;
  logic        rd_sel_rst;
  logic        rd_sel_scr;
  s_axi_miso_t wr_tgt;
  s_axi_miso_t rd_tgt;

  assign aw_win  = axi_mosi.awaddr[19:16];
  assign ar_win  = axi_mosi.araddr[19:16];
  assign aw_fire = axi_mosi.awvalid && !wr_open_ff;
  assign ar_fire = axi_mosi.arvalid && !rd_open_ff;
  assign w_fire  = axi_mosi.wvalid && axi_miso.wready;

  assign ar_unmapped = ar_fire && (ar_win != RST_CTRL_WINDOW) && (ar_win != SCRATCH_WINDOW);

  // the latched window picks the target for the rest of the transaction
  assign wr_sel_rst  = wr_open_ff && (wr_win_ff == RST_CTRL_WINDOW);
  assign wr_sel_scr  = wr_open_ff && (wr_win_ff == SCRATCH_WINDOW);
  assign wr_unmapped = wr_open_ff && !wr_sel_rst && !wr_sel_scr;
  assign rd_sel_rst  = rd_open_ff && (rd_win_ff == RST_CTRL_WINDOW);
  assign rd_sel_scr  = rd_open_ff && (rd_win_ff == SCRATCH_WINDOW);

  always_comb begin
    rst_mosi         = axi_mosi;
    rst_mosi.awvalid = aw_fire && (aw_win == RST_CTRL_WINDOW);
    rst_mosi.wvalid  = axi_mosi.wvalid && wr_sel_rst;
    rst_mosi.bready  = wr_sel_rst && !bvalid_ff;   // taken as soon as our register is free
    rst_mosi.arvalid = ar_fire && (ar_win == RST_CTRL_WINDOW);
    rst_mosi.rready  = rd_sel_rst && !rvalid_ff;

    scratch_mosi         = axi_mosi;
    scratch_mosi.awvalid = aw_fire && (aw_win == SCRATCH_WINDOW);
    scratch_mosi.wvalid  = axi_mosi.wvalid && wr_sel_scr;
    scratch_mosi.bready  = wr_sel_scr && !bvalid_ff;
    scratch_mosi.arvalid = ar_fire && (ar_win == SCRATCH_WINDOW);
    scratch_mosi.rready  = rd_sel_scr && !rvalid_ff;
  end

  always_comb begin
    wr_tgt = '0;
    rd_tgt = '0;
    if (wr_sel_rst) begin
      wr_tgt = rst_miso;
    end else if (wr_sel_scr) begin
      wr_tgt = scratch_miso;
    end
    if (rd_sel_rst) begin
      rd_tgt = rst_miso;
    end else if (rd_sel_scr) begin
      rd_tgt = scratch_miso;
    end
  end

  always_comb begin
    axi_miso         = '0;
    axi_miso.awready = !wr_open_ff;
    // an unmapped W is swallowed here until its error response is out
    axi_miso.wready  = wr_unmapped ? !bvalid_ff : wr_tgt.wready;
    axi_miso.bvalid  = bvalid_ff;
    axi_miso.bresp   = bresp_ff;
    axi_miso.arready = !rd_open_ff;
    axi_miso.rvalid  = rvalid_ff;
    axi_miso.rdata   = rdata_ff;
    axi_miso.rresp   = rresp_ff;
    axi_miso.rlast   = rlast_ff;
  end

  always_ff @(posedge clk) begin
    if (rd_rst_ff) begin
      wr_open_ff <= 1'b0;
      rd_open_ff <= 1'b0;
      bvalid_ff  <= 1'b0;
      rvalid_ff  <= 1'b0;
    end else begin
      if (aw_fire) begin
        wr_open_ff <= 1'b1;
      end else if (bvalid_ff && axi_mosi.bready) begin
        wr_open_ff <= 1'b0;
      end
      if (bvalid_ff) begin
        bvalid_ff <= !axi_mosi.bready;
      end else if ((wr_unmapped && w_fire) || wr_tgt.bvalid) begin
        bvalid_ff <= 1'b1;
      end

      if (ar_fire) begin
        rd_open_ff <= 1'b1;
      end else if (rvalid_ff && axi_mosi.rready) begin
        rd_open_ff <= 1'b0;
      end
      if (rvalid_ff) begin
        rvalid_ff <= !axi_mosi.rready;
      end else if (ar_unmapped || rd_tgt.rvalid) begin
        rvalid_ff <= 1'b1;
      end
    end
  end

  // window and response payload, held steady while the valid flags are up
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_win_ff <= aw_win;
    end
    if (ar_fire) begin
      rd_win_ff <= ar_win;
    end
    if (!bvalid_ff) begin
      bresp_ff <= wr_unmapped ? RESP_DECERR : wr_tgt.bresp;
    end
    if (!rvalid_ff) begin
      if (ar_unmapped) begin
        rdata_ff <= DECERR_DATA;
        rresp_ff <= RESP_DECERR;
        rlast_ff <= 1'b1;
      end else begin
        rdata_ff <= rd_tgt.rdata;
        rresp_ff <= rd_tgt.rresp;
        rlast_ff <= rd_tgt.rlast;
      end
    end
  end

  // a read response toward the master always belongs to an accepted AR
  rvalid_needs_open: assert property (@(posedge clk) disable iff (rd_rst_ff)
    $rose(axi_miso.rvalid) |-> rd_open_ff);

endmodule

// ==== verilog/scratch_regs.sv ====
// scratch word target on the AXI-lite bus
// four words that keep their value across a core soft reset
`timescale 1ns/1ps

module scratch_regs (
  input  logic                      clk,
  input  logic                      rd_rst_ff,
  input  soc_ctrl_pkg::s_axi_mosi_t axi_mosi,
  output soc_ctrl_pkg::s_axi_miso_t axi_miso
);
  import soc_ctrl_pkg::*;

  data_t                    words_ff [SCRATCH_WORDS];
  logic                     wr_pend_ff;
  logic [SCRATCH_IDX_W-1:0] wr_idx_ff;  // word select from address bits 3 to 2
  logic                     rd_pend_ff;
  logic [SCRATCH_IDX_W-1:0] rd_idx_ff;
  logic                     bvalid_ff;
  logic                     w_fire;

  assign w_fire = axi_mosi.wvalid && wr_pend_ff;

  always_comb begin
    axi_miso         = '0;
    axi_miso.awready = 1'b1;
    axi_miso.wready  = wr_pend_ff;
    axi_miso.bvalid  = bvalid_ff;
    axi_miso.bresp   = RESP_OKAY;
    axi_miso.arready = 1'b1;
    axi_miso.rvalid  = rd_pend_ff;
    axi_miso.rdata   = words_ff[rd_idx_ff];
    axi_miso.rresp   = RESP_OKAY;
    axi_miso.rlast   = rd_pend_ff;
  end

  always_ff @(posedge clk) begin
    if (rd_rst_ff) begin
      wr_pend_ff <= 1'b0;
      rd_pend_ff <= 1'b0;
      bvalid_ff  <= 1'b0;
      for (int i = 0; i < SCRATCH_WORDS; i++) begin
        words_ff[i] <= '0;
      end
    end else begin
      wr_pend_ff <= axi_mosi.awvalid || (wr_pend_ff && !w_fire);
      rd_pend_ff <= axi_mosi.arvalid || (rd_pend_ff && !axi_mosi.rready);
      if (w_fire) begin
        bvalid_ff             <= 1'b1;
        words_ff[wr_idx_ff]   <= axi_mosi.wdata;
      end else if (axi_mosi.bready) begin
        bvalid_ff <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (axi_mosi.awvalid) begin
      wr_idx_ff <= axi_mosi.awaddr[SCRATCH_IDX_W+1:2];
    end
    if (axi_mosi.arvalid) begin
      rd_idx_ff <= axi_mosi.araddr[SCRATCH_IDX_W+1:2];
    end
  end

endmodule

// ==== verilog/boot_seq.sv ====
// boot sequencer FSM
// holds the core in reset for a fixed count after power-on or soft reset
// and captures the boot address as the core leaves reset
`timescale 1ns/1ps

module boot_seq (
  input  logic                clk,
  input  logic                rd_rst_ff,
  input  logic                soft_rst_req,
  input  soc_ctrl_pkg::data_t rst_vector,
  output logic                core_rst,
  output soc_ctrl_pkg::addr_t boot_addr
);
  import soc_ctrl_pkg::*;

  boot_state_t           state_ff;
  logic [HOLD_CNT_W-1:0] hold_cnt_ff;
  logic                  hold_done;
  logic                  enter_run;

  assign hold_done = hold_cnt_ff == HOLD_CNT_W'(CORE_RST_HOLD - 1);
  assign enter_run = !rd_rst_ff && !soft_rst_req && (state_ff == HOLD) && hold_done;
  assign core_rst  = state_ff == HOLD;

  always_ff @(posedge clk) begin
    if (rd_rst_ff || soft_rst_req) begin  // a soft request restarts the count
      state_ff    <= HOLD;
      hold_cnt_ff <= '0;
    end else begin
      case (state_ff)
        HOLD: begin
          if (hold_done) begin
            state_ff <= RUN;
          end else begin
            hold_cnt_ff <= hold_cnt_ff + 1'b1;
          end
        end
        default: state_ff <= RUN;
      endcase
    end
  end

  // boot address stays frozen for the whole RUN period
  always_ff @(posedge clk) begin
    if (enter_run) begin
      boot_addr <= rst_vector;
    end
  end

  // a soft request keeps the core in reset for the full hold time
  soft_rst_hold: assert property (@(posedge clk) disable iff (rd_rst_ff)
    soft_rst_req |=> ((state_ff == HOLD) && core_rst) [*CORE_RST_HOLD]);

endmodule

// ==== verilog/soc_ctrl_top.sv ====
// system-control subsystem top
// decoder, reset controller, scratch words and boot sequencer
`timescale 1ns/1ps

module soc_ctrl_top (
  input  logic                      clk,
  input  logic                      rd_rst_ff,
  input  soc_ctrl_pkg::s_axi_mosi_t axi_mosi,
  output soc_ctrl_pkg::s_axi_miso_t axi_miso,
  output logic                      core_rst,
  output soc_ctrl_pkg::addr_t       boot_addr
);
  import soc_ctrl_pkg::*;

  s_axi_mosi_t rst_mosi;
  s_axi_miso_t rst_miso;
  s_axi_mosi_t scratch_mosi;
  s_axi_miso_t scratch_miso;
  data_t       rst_vector;
  logic        soft_rst_req;  // one-cycle pulse from the soft-reset register

  axi_periph_decode u_decode (
    .clk          (clk),
    .rd_rst_ff    (rd_rst_ff),
    .axi_mosi     (axi_mosi),
    .axi_miso     (axi_miso),
    .rst_mosi     (rst_mosi),
    .rst_miso     (rst_miso),
    .scratch_mosi (scratch_mosi),
    .scratch_miso (scratch_miso)
  );

  rst_ctrl u_rst_ctrl (
    .clk          (clk),
    .rd_rst_ff    (rd_rst_ff),
    .axi_mosi     (rst_mosi),
    .axi_miso     (rst_miso),
    .rst_vector   (rst_vector),
    .soft_rst_req (soft_rst_req)
  );

  scratch_regs u_scratch (
    .clk       (clk),
    .rd_rst_ff (rd_rst_ff),
    .axi_mosi  (scratch_mosi),
    .axi_miso  (scratch_miso)
  );

  boot_seq u_boot_seq (
    .clk          (clk),
    .rd_rst_ff    (rd_rst_ff),
    .soft_rst_req (soft_rst_req),
    .rst_vector   (rst_vector),
    .core_rst     (core_rst),
    .boot_addr    (boot_addr)
  );

endmodule

// ==== tb/tb_axi_tasks.svh ====
// write and read tasks for the AXI-lite master port of the testbench
// inputs change 1 ns after a rising edge, outputs are sampled on falling edges
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// full write: AW, then W, then B; bready can be held back after bvalid shows up
task automatic axi_write(input addr_t addr, input data_t data, input int bready_delay,
                         output resp_t resp, output int bvalid_cycle);
  @(posedge clk);
  #1;
  axi_mosi.awvalid = 1'b1;
  axi_mosi.awaddr  = addr;
  @(negedge clk);
  while (!axi_miso.awready) @(negedge clk);
  @(posedge clk);
  #1;
  axi_mosi.awvalid = 1'b0;
  axi_mosi.wvalid  = 1'b1;
  axi_mosi.wdata   = data;
  @(negedge clk);
  while (!axi_miso.wready) @(negedge clk);
  @(posedge clk);
  #1;
  axi_mosi.wvalid = 1'b0;
  axi_mosi.bready = (bready_delay == 0);
  @(negedge clk);
  while (!axi_miso.bvalid) @(negedge clk);
  bvalid_cycle = cycle_cnt;  // cycle in which the response first shows up
  resp         = axi_miso.bresp;
  if (bready_delay > 0) begin
    repeat (bready_delay) @(posedge clk);
    #1;
    axi_mosi.bready = 1'b1;
  end
  @(posedge clk);
  #1;
  axi_mosi.bready = 1'b0;
endtask

task automatic axi_read(input addr_t addr, output data_t data, output resp_t resp);
  @(posedge clk);
  #1;
  axi_mosi.arvalid = 1'b1;
  axi_mosi.araddr  = addr;
  @(negedge clk);
  while (!axi_miso.arready) @(negedge clk);
  @(posedge clk);
  #1;
  axi_mosi.arvalid = 1'b0;
  axi_mosi.rready  = 1'b1;
  @(negedge clk);
  while (!axi_miso.rvalid) @(negedge clk);
  data = axi_miso.rdata;
  resp = axi_miso.rresp;
  @(posedge clk);
  #1;
  axi_mosi.rready = 1'b0;
endtask

`endif

// ==== tb/tb_soc_ctrl.sv ====
// testbench for the system-control subsystem
// boot timing, reset vector, soft reset, scratch words, decode errors, back-pressure
`timescale 1ns/1ps

module tb_soc_ctrl;
  import soc_ctrl_pkg::*;

  localparam int CYCLE_LIMIT = 2000;  // all tests together take a few hundred cycles

  logic        clk = 1'b0;
  logic        rd_rst_ff;
  s_axi_mosi_t axi_mosi;
  s_axi_miso_t axi_miso;
  logic        core_rst;
  addr_t       boot_addr;

  int    cycle_cnt = 0;
  int    errors = 0;
  int    errors_at_start = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    run_len = 0;     // core_rst high cycles seen so far in the current pulse
  int    last_len = 0;
  int    rise_cycle = 0;
  int    rst_pulses = 0;
  data_t lcg_state = 32'h2ece_499a;

  `include "tb_axi_tasks.svh"

  soc_ctrl_top uut (
    .clk       (clk),
    .rd_rst_ff (rd_rst_ff),
    .axi_mosi  (axi_mosi),
    .axi_miso  (axi_miso),
    .core_rst  (core_rst),
    .boot_addr (boot_addr)
  );

  always #10 clk = ~clk;

  function automatic data_t lcg_step(input data_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_rand(output data_t v);
    lcg_state = lcg_step(lcg_state);
    v         = lcg_state;
  endtask

  // the window sits in address bits 19 to 16, the offset in the low half
  function automatic addr_t reg_addr(input win_t win, input reg_off_t off);
    return {12'h000, win, off};
  endfunction

  task automatic expect_eq(input string sig, input data_t exp, input data_t act);
    assert (act === exp) else begin
      $display("[FAIL] %0t %s expected %h got %h", $time, sig, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end else begin
      $display("test %0d %s: passed", tests_run, name);
    end
    errors_at_start = errors;
  endtask

  // measures every core reset pulse outside of the bus reset
  always @(negedge clk) begin
    if (rd_rst_ff) begin
      run_len = 0;
    end else if (core_rst) begin
      if (run_len == 0) begin
        rise_cycle = cycle_cnt;
      end
      run_len = run_len + 1;
    end else if (run_len != 0) begin
      last_len   = run_len;
      rst_pulses = rst_pulses + 1;
      run_len    = 0;
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout, the run did not complete within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  bresp_held: assert property (@(posedge clk) disable iff (rd_rst_ff)
    (axi_miso.bvalid && !axi_mosi.bready) |=> (axi_miso.bvalid && $stable(axi_miso.bresp)))
    else begin
      errors++;
      $display("write response changed while bready was low at %0t", $time);
    end

  aw_blocked: assert property (@(posedge clk) disable iff (rd_rst_ff)
    axi_miso.bvalid |-> !axi_miso.awready)
    else begin
      errors++;
      $display("awready was high while a write response was pending at %0t", $time);
    end

  boot_addr_frozen: assert property (@(posedge clk) disable iff (rd_rst_ff)
    (!core_rst && !$past(core_rst)) |-> $stable(boot_addr))
    else begin
      errors++;
      $display("boot_addr changed while the core was running at %0t", $time);
    end

  rst_rise_after_req: assert property (@(posedge clk) disable iff (rd_rst_ff)
    $rose(core_rst) |-> $past(uut.soft_rst_req))
    else begin
      errors++;
      $display("core_rst rose without a soft-reset request the cycle before at %0t", $time);
    end

  rlast_with_rvalid: assert property (@(posedge clk) disable iff (rd_rst_ff)
    axi_miso.rvalid |-> axi_miso.rlast)
    else begin
      errors++;
      $display("rlast was low on a read response at %0t", $time);
    end

  initial begin
    data_t vec;
    data_t val;
    data_t rd_data;
    data_t scr [SCRATCH_WORDS];
    resp_t resp;
    int    bcyc;
    int    pulses_before;

    axi_mosi  = '0;
    rd_rst_ff = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rd_rst_ff = 1'b0;

    wait (rst_pulses == 1);
    expect_eq("core_rst high cycles", CORE_RST_HOLD, last_len);
    expect_eq("boot_addr", RST_VECTOR_DEFAULT, boot_addr);
    finish_test("power-on boot");

    next_rand(vec);
    axi_write(reg_addr(RST_CTRL_WINDOW, REG_RST_VECTOR), vec, 0, resp, bcyc);
    expect_eq("bresp", data_t'(RESP_OKAY), data_t'(resp));
    axi_read(reg_addr(RST_CTRL_WINDOW, REG_RST_VECTOR), rd_data, resp);
    expect_eq("rresp", data_t'(RESP_OKAY), data_t'(resp));
    expect_eq("rdata", vec, rd_data);
    expect_eq("boot_addr", RST_VECTOR_DEFAULT, boot_addr);
    finish_test("reset vector write and read");

    // scratch words go in before the soft reset and are read back after it
    for (int i = 0; i < SCRATCH_WORDS; i++) begin
      next_rand(scr[i]);
      axi_write(reg_addr(SCRATCH_WINDOW, reg_off_t'(i * 4)), scr[i], 0, resp, bcyc);
      expect_eq("bresp", data_t'(RESP_OKAY), data_t'(resp));
    end

    pulses_before = rst_pulses;
    axi_write(reg_addr(RST_CTRL_WINDOW, REG_SOFT_RST), 32'h1, 0, resp, bcyc);
    wait (rst_pulses == pulses_before + 1);
    expect_eq("bresp", data_t'(RESP_OKAY), data_t'(resp));
    // the core reset starts together with the registered write response
    expect_eq("core_rst rise cycle", bcyc, rise_cycle);
    expect_eq("core_rst high cycles", CORE_RST_HOLD, last_len);
    expect_eq("boot_addr", vec, boot_addr);
    finish_test("soft reset");

    for (int i = 0; i < SCRATCH_WORDS; i++) begin
      axi_read(reg_addr(SCRATCH_WINDOW, reg_off_t'(i * 4)), rd_data, resp);
      expect_eq("rresp", data_t'(RESP_OKAY), data_t'(resp));
      expect_eq("rdata", scr[i], rd_data);
    end
    finish_test("scratch words across soft reset");

    axi_write(reg_addr(4'd5, 16'h0000), 32'h1234_5678, 0, resp, bcyc);
    expect_eq("bresp", data_t'(RESP_DECERR), data_t'(resp));
    axi_read(reg_addr(4'd5, 16'h0000), rd_data, resp);
    expect_eq("rresp", data_t'(RESP_DECERR), data_t'(resp));
    expect_eq("rdata", DECERR_DATA, rd_data);
    finish_test("unmapped window");

    next_rand(val);
    axi_write(reg_addr(SCRATCH_WINDOW, 16'h000c), val, 10, resp, bcyc);
    expect_eq("bresp", data_t'(RESP_OKAY), data_t'(resp));
    // the response is gone once bready has been seen
    expect_eq("bvalid", data_t'(1'b0), data_t'(axi_miso.bvalid));
    axi_read(reg_addr(SCRATCH_WINDOW, 16'h000c), rd_data, resp);
    expect_eq("rdata", val, rd_data);
    finish_test("write response back-pressure");

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+tb
verilog/soc_ctrl_pkg.sv
verilog/rst_ctrl.sv
verilog/axi_periph_decode.sv
verilog/scratch_regs.sv
verilog/boot_seq.sv
verilog/soc_ctrl_top.sv
tb/tb_soc_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench and DUT with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_soc_ctrl -f filelist.f || exit 1
./obj_dir/Vtb_soc_ctrl > sim.log 2>&1
cat sim.log
# a missing pass line also counts as a failure
grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST OK" sim.log
